/* design/arcade_inputs_top.sv */
`timescale 1ns/1ps
`default_nettype none

module arcade_inputs_top (
	input  wire                      CLK_12M,
	input  wire                      rst_n,
	input  wire [10:0]               ps2_key,
	input  wire [24:0]               ps2_mouse,
	input  wire [8:0]                joy,
	input  wire [3:0]                user_in,
	input  wire                      ioctl_wr,
	input  wire [7:0]                ioctl_index,
	input  wire [24:0]               ioctl_addr,
	input  wire ctrl_pkg::dip_byte_t ioctl_dout,
	output wire ctrl_pkg::phase_t    spinner,
	output wire                      use_io,
	output wire                      btn_shot_n,
	output wire                      btn_1p_start_n,
	output wire                      btn_2p_start_n,
	output wire                      coin1,
	output wire                      coin2,
	output wire                      btn_service_n,
	output wire ctrl_pkg::dip_byte_t dip_sw
);
	import ctrl_pkg::*;

	logic      m_left;
	logic      m_right;
	logic      m_fast;
	logic      emu_step;
	dial_dir_e emu_dir;
	logic      emu_activity;
	logic      raw_step;
	dial_dir_e raw_dir;
	phase_t    emu_phase; // Mouse and pad driven
	phase_t    raw_phase; // User port driven

	////////////////////////////////////////
	// Buttons

	player_controls player_controls_i (
		.CLK_12M        (CLK_12M),
		.rst_n          (rst_n),
		.ps2_key        (ps2_key),
		.joy            (joy),
		.mouse_btn      (ps2_mouse[1:0]),
		.fire_pin_n     (user_in[3]),
		.m_left         (m_left),
		.m_right        (m_right),
		.m_fast         (m_fast),
		.btn_shot_n     (btn_shot_n),
		.btn_1p_start_n (btn_1p_start_n),
		.btn_2p_start_n (btn_2p_start_n),
		.coin1          (coin1),
		.coin2          (coin2),
		.btn_service_n  (btn_service_n)
	);

	////////////////////////////////////////
	// Emulated spinner

	spinner_emulator spinner_emulator_i (
		.CLK_12M      (CLK_12M),
		.rst_n        (rst_n),
		.mouse_toggle (ps2_mouse[24]),
		.mouse_dx     (ps2_mouse[15:8]),
		.mouse_sign   (ps2_mouse[4]),
		.m_left       (m_left),
		.m_right      (m_right),
		.m_fast       (m_fast),
		.emu_step     (emu_step),
		.emu_dir      (emu_dir),
		.emu_activity (emu_activity)
	);

	quadrature_phase emu_phase_i (
		.CLK_12M (CLK_12M),
		.rst_n   (rst_n),
		.step    (emu_step),
		.dir     (emu_dir),
		.phase   (emu_phase)
	);

	////////////////////////////////////////
	// Physical encoder

	encoder_reducer encoder_reducer_i (
		.CLK_12M  (CLK_12M),
		.rst_n    (rst_n),
		.enc_pins (user_in[1:0]),
		.raw_step (raw_step),
		.raw_dir  (raw_dir)
	);

	quadrature_phase raw_phase_i (
		.CLK_12M (CLK_12M),
		.rst_n   (rst_n),
		.step    (raw_step),
		.dir     (raw_dir),
		.phase   (raw_phase)
	);

	spinner_select spinner_select_i (
		.CLK_12M      (CLK_12M),
		.rst_n        (rst_n),
		.enc_pins     (user_in[1:0]),
		.emu_activity (emu_activity),
		.emu_phase    (emu_phase),
		.raw_phase    (raw_phase),
		.spinner      (spinner),
		.use_io       (use_io)
	);

	// DIP bank from the download stream
	dip_switch_bank dip_switch_bank_i (
		.CLK_12M     (CLK_12M),
		.rst_n       (rst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dip_sw      (dip_sw)
	);

endmodule

`default_nettype wire

/* design/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

	////////////////////////////////////////
	// Types

	typedef logic [1:0]         phase_t;     // AB encoder lines, idle high
	typedef logic signed [11:0] position_t;  // Spinner travel still owed
	typedef logic [7:0]         scan_code_t; // PS/2 set 2 code, also the mouse delta
	typedef logic [7:0]         dip_byte_t;

	// Step direction of a quadrature phase
	typedef enum logic {
		dial_fwd = 1'b0, // 00 -> 01 -> 11 -> 10
		dial_rev = 1'b1  // 00 -> 10 -> 11 -> 01
	} dial_dir_e;

	////////////////////////////////////////
	// Timing and constants

	localparam phase_t    PHASE_IDLE    = 2'b11;
	localparam int        CE_DIV_STEP   = 1500;  // 6 MHz enables per drain step
	localparam int        PAD_REPEAT    = 48000; // Roughly 8 ms, a mouse poll period
	localparam position_t PAD_STEP_SLOW = 12'sd4;
	localparam position_t PAD_STEP_FAST = 12'sd9;

	// Keyboard map
	localparam scan_code_t KEY_START1  = 8'h16; // 1
	localparam scan_code_t KEY_START2  = 8'h1E; // 2
	localparam scan_code_t KEY_COIN1   = 8'h2E; // 5
	localparam scan_code_t KEY_COIN2   = 8'h36; // 6
	localparam scan_code_t KEY_SERVICE = 8'h46; // 9
	localparam scan_code_t KEY_FAST    = 8'h11; // Alt
	localparam scan_code_t KEY_LEFT    = 8'h6B; // Cursor left
	localparam scan_code_t KEY_RIGHT   = 8'h74; // Cursor right
	localparam scan_code_t KEY_FIRE    = 8'h29; // Space

	localparam logic [7:0] DIP_INDEX = 8'd254; // Download slot of the DIP bank
	localparam int         DIP_BANKS = 8;

endpackage

`default_nettype wire

/* design/dip_switch_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module dip_switch_bank (
	input  wire                      CLK_12M,
	input  wire                      rst_n,
	input  wire                      ioctl_wr,
	input  wire [7:0]                ioctl_index,
	input  wire [24:0]               ioctl_addr,
	input  wire ctrl_pkg::dip_byte_t ioctl_dout,
	output ctrl_pkg::dip_byte_t      dip_sw
);
	import ctrl_pkg::*;

	dip_byte_t dip_mem [DIP_BANKS]; // Downloaded bytes, stored active low
	logic      dip_we;

	// Only the first eight addresses of slot 254
	assign dip_we = ioctl_wr && (ioctl_index == DIP_INDEX) && (ioctl_addr[24:3] == '0);

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DIP_BANKS; i++)
				dip_mem[i] <= '0;
		end else if (dip_we) begin
			dip_mem[ioctl_addr[2:0]] <= ioctl_dout;
		end
	end

	assign dip_sw = ~dip_mem[0]; // Core reads bank 0 inverted

endmodule

`default_nettype wire

/* design/encoder_reducer.sv */
`timescale 1ns/1ps
`default_nettype none

module encoder_reducer (
	input  wire                 CLK_12M,
	input  wire                 rst_n,
	input  wire [1:0]           enc_pins, // [0] A, [1] B
	output logic                raw_step,
	output ctrl_pkg::dial_dir_e raw_dir
);
	import ctrl_pkg::*;

	logic [1:0] pins_s;  // Pins sampled off the user port
	logic       enc_a_q; // A one sample back

	////////////////////////////////////////
	// Edges on A only, B just gives the sense
	// so a 600 line encoder reads as 300

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			pins_s   <= 2'b11; // Open drain lines idle high
			enc_a_q  <= 1'b1;
			raw_step <= 1'b0;
			raw_dir  <= dial_fwd;
		end else begin
			pins_s   <= enc_pins;
			enc_a_q  <= pins_s[0];
			raw_step <= pins_s[0] != enc_a_q;
			// A unlike B after the edge means forward
			raw_dir  <= (pins_s[0] ^ pins_s[1]) ? dial_fwd : dial_rev;
		end
	end

endmodule

`default_nettype wire

/* design/player_controls.sv */
`timescale 1ns/1ps
`default_nettype none

module player_controls (
	input  wire        CLK_12M,
	input  wire        rst_n,
	input  wire [10:0] ps2_key,    // [10] event toggle, [9] pressed, [7:0] code
	input  wire [8:0]  joy,
	input  wire [1:0]  mouse_btn,
	input  wire        fire_pin_n, // Cabinet fire on the user port
	output logic       m_left,
	output logic       m_right,
	output logic       m_fast,
	output logic       btn_shot_n,
	output logic       btn_1p_start_n,
	output logic       btn_2p_start_n,
	output logic       coin1,
	output logic       coin2,
	output logic       btn_service_n
);
	import ctrl_pkg::*;

	logic       key_old;   // Last seen event toggle
	logic       key_event;
	scan_code_t key_code;
	logic       key_pressed;
	logic       kb_fire, kb_left, kb_right, kb_fast;
	logic       kb_coin1, kb_coin2, kb_service, kb_start1, kb_start2;

	assign key_event   = ps2_key[10] != key_old; // Any edge is one key event
	assign key_code    = ps2_key[7:0];
	assign key_pressed = ps2_key[9];

	////////////////////////////////////////
	// Keyboard, one held level per key

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			key_old    <= 1'b0;
			kb_fire    <= 1'b0;
			kb_left    <= 1'b0;
			kb_right   <= 1'b0;
			kb_fast    <= 1'b0;
			kb_coin1   <= 1'b0;
			kb_coin2   <= 1'b0;
			kb_service <= 1'b0;
			kb_start1  <= 1'b0;
			kb_start2  <= 1'b0;
		end else begin
			key_old <= ps2_key[10];
			if (key_event) begin
				case (key_code) // Make sets the level, break clears it
					KEY_START1:  kb_start1  <= key_pressed;
					KEY_START2:  kb_start2  <= key_pressed;
					KEY_COIN1:   kb_coin1   <= key_pressed;
					KEY_COIN2:   kb_coin2   <= key_pressed;
					KEY_SERVICE: kb_service <= key_pressed;
					KEY_FAST:    kb_fast    <= key_pressed;
					KEY_LEFT:    kb_left    <= key_pressed;
					KEY_RIGHT:   kb_right   <= key_pressed;
					KEY_FIRE:    kb_fire    <= key_pressed;
					default:     ;          // Other keys ignored
				endcase
			end
		end
	end

	////////////////////////////////////////
	// Source merge

	assign m_left  = kb_left  | joy[1];
	assign m_right = kb_right | joy[0];
	assign m_fast  = kb_fast  | joy[5];

	// Fire comes from four places, the pin is already active low
	assign btn_shot_n     = ~(kb_fire | joy[4] | (|mouse_btn) | ~fire_pin_n);
	assign btn_1p_start_n = ~(kb_start1 | joy[6]);
	assign btn_2p_start_n = ~(kb_start2 | joy[8]);
	assign btn_service_n  = ~kb_service;
	assign coin1          = kb_coin1 | joy[7]; // Coins go to the core active high
	assign coin2          = kb_coin2;

endmodule

`default_nettype wire

/* design/quadrature_phase.sv */
`timescale 1ns/1ps
`default_nettype none

module quadrature_phase (
	input  wire                      CLK_12M,
	input  wire                      rst_n,
	input  wire                      step,
	input  wire ctrl_pkg::dial_dir_e dir,
	output ctrl_pkg::phase_t         phase
);
	import ctrl_pkg::*;

	logic   rev;
	phase_t phase_next;

	assign rev = (dir == dial_rev);

	// Gray walk, one line changes per step
	always_comb begin
		case ({rev, phase})
			3'b0_00: phase_next = 2'b01;
			3'b0_01: phase_next = 2'b11;
			3'b0_11: phase_next = 2'b10;
			3'b0_10: phase_next = 2'b00;
			3'b1_00: phase_next = 2'b10; // Reverse walk
			3'b1_10: phase_next = 2'b11;
			3'b1_11: phase_next = 2'b01;
			3'b1_01: phase_next = 2'b00;
			default: phase_next = phase;
		endcase
	end

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n)
			phase <= PHASE_IDLE;
		else if (step)
			phase <= phase_next;
	end

	a_gray_step: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		$changed(phase) |-> $past(step) && ($countones(phase ^ $past(phase)) == 1));

endmodule

`default_nettype wire

/* design/spinner_emulator.sv */
`timescale 1ns/1ps
`default_nettype none

module spinner_emulator (
	input  wire                   CLK_12M,
	input  wire                   rst_n,
	input  wire                   mouse_toggle, // Flips once per mouse report
	input  wire ctrl_pkg::scan_code_t mouse_dx,
	input  wire                   mouse_sign,
	input  wire                   m_left,
	input  wire                   m_right,
	input  wire                   m_fast,
	output logic                  emu_step,     // One quadrature step
	output ctrl_pkg::dial_dir_e   emu_dir,
	output logic                  emu_activity  // Mouse report or pad tick
);
	import ctrl_pkg::*;

	logic        ce_6m;      // Half rate enable
	logic [10:0] step_div;   // Counts enables between drain steps
	logic [15:0] pad_cnt;    // D-pad repeat counter
	logic        mouse_old;
	position_t   position;
	position_t   mouse_delta;
	position_t   pad_load;
	logic        pad_held;
	logic        pad_tick;
	logic        mouse_event;
	logic        step_due;

	// Sign extend the 9 bit mouse delta
	assign mouse_delta = {{4{mouse_sign}}, mouse_dx};
	assign pad_held    = m_left | m_right;
	assign pad_tick    = pad_held && (pad_cnt == 16'(PAD_REPEAT - 1));
	assign mouse_event = ce_6m && (mouse_old != mouse_toggle);

	// Right turns positive, left negative
	always_comb begin
		if (m_right)
			pad_load = m_fast ? PAD_STEP_FAST : PAD_STEP_SLOW;
		else
			pad_load = m_fast ? -PAD_STEP_FAST : -PAD_STEP_SLOW;
	end

	// Drain one count per divider wrap while travel is owed
	assign step_due = ce_6m && (step_div == '0) && (position != '0);

	////////////////////////////////////////
	// Accumulator and strobes

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			ce_6m        <= 1'b0;
			step_div     <= '0;
			pad_cnt      <= '0;
			mouse_old    <= 1'b0;
			position     <= '0;
			emu_step     <= 1'b0;
			emu_dir      <= dial_fwd;
			emu_activity <= 1'b0;
		end else begin
			ce_6m        <= ~ce_6m;
			emu_step     <= step_due;                  // Phase moves the cycle after
			emu_activity <= mouse_event || (ce_6m && pad_held);
			if (step_due)
				emu_dir <= position[11] ? dial_fwd : dial_rev; // Negative spins forward

			if (ce_6m) begin
				if (step_div == 11'(CE_DIV_STEP - 1))
					step_div <= '0;
				else
					step_div <= step_div + 11'd1;

				if (step_due) begin
					if (position[11])
						position <= position + 12'sd1;
					else
						position <= position - 12'sd1;
				end

				mouse_old <= mouse_toggle;
				// Top bits apart means near overflow, drop the report
				if (mouse_event && (position[11] == position[10]))
					position <= position + mouse_delta;

				if (pad_held) begin
					if (pad_tick) begin
						pad_cnt  <= '0;
						position <= pad_load; // Load, not add
					end else begin
						pad_cnt <= pad_cnt + 16'd1;
					end
				end else begin
					pad_cnt <= '0; // Release restarts the repeat
				end
			end
		end
	end

	// Each drain step takes one count off the travel, in the step's direction
	a_drain_one: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		emu_step && !$past(mouse_event) && !$past(ce_6m && pad_tick) |->
		position == $past(position) + ((emu_dir == dial_fwd) ? 12'sd1 : -12'sd1));

endmodule

`default_nettype wire

/* design/spinner_select.sv */
`timescale 1ns/1ps
`default_nettype none

module spinner_select (
	input  wire                   CLK_12M,
	input  wire                   rst_n,
	input  wire [1:0]             enc_pins,
	input  wire                   emu_activity,
	input  wire ctrl_pkg::phase_t emu_phase,
	input  wire ctrl_pkg::phase_t raw_phase,
	output ctrl_pkg::phase_t      spinner,
	output logic                  use_io       // 1 selects the physical encoder
);
	logic [1:0] pins_q;
	logic       pin_change;

	assign pin_change = pins_q != enc_pins;

	always_ff @(posedge CLK_12M or negedge rst_n) begin
		if (!rst_n) begin
			pins_q <= 2'b11;
			use_io <= 1'b0;
		end else begin
			pins_q <= enc_pins;
			if (pin_change)
				use_io <= 1'b1; // Encoder motion takes priority
			else if (emu_activity)
				use_io <= 1'b0;
		end
	end

	assign spinner = use_io ? raw_phase : emu_phase;

	// Outside a handover the output walks one Gray step at a time
	a_out_gray: assert property (@(posedge CLK_12M) disable iff (!rst_n)
		$changed(spinner) && $stable(use_io) |-> $countones(spinner ^ $past(spinner)) == 1);

endmodule

`default_nettype wire

/* project.f */
+incdir+verification
design/ctrl_pkg.sv
design/player_controls.sv
design/spinner_emulator.sv
design/quadrature_phase.sv
design/encoder_reducer.sv
design/spinner_select.sv
design/dip_switch_bank.sv
design/arcade_inputs_top.sv
verification/tb_arcade_inputs.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_arcade_inputs -f project.f \
	&& ./obj_dir/Vtb_arcade_inputs | tee /dev/stderr | grep -q "Simulation PASSED" \
	&& echo "run.sh: run passed" \
	|| { echo "run.sh: run failed"; exit 1; }

/* verification/tb_reference.svh */
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

////////////////////////////////////////
// Keyboard map and button merge

// Slot order in the held-key vector
// 0 start1, 1 start2, 2 coin1, 3 coin2, 4 service, 5 fast, 6 left, 7 right, 8 fire
function automatic logic [7:0] key_code_of(input int slot);
	case (slot)
		0:       return 8'h16;
		1:       return 8'h1E;
		2:       return 8'h2E;
		3:       return 8'h36;
		4:       return 8'h46;
		5:       return 8'h11;
		6:       return 8'h6B;
		7:       return 8'h74;
		8:       return 8'h29;
		default: return 8'h1C; // Letter A, no game function
	endcase
endfunction

// Result as {shot_n, start1_n, start2_n, coin1, coin2, service_n}
function automatic logic [5:0] merge_buttons(input logic [8:0] held, input logic [8:0] joy_v,
		input logic [1:0] mbtn, input logic fire_n);
	logic shot;
	shot = held[8] || joy_v[4] || (mbtn != 2'b00) || !fire_n; // Any fire source
	return {!shot, !(held[0] || joy_v[6]), !(held[1] || joy_v[8]),
		held[2] || joy_v[7], held[3], !held[4]};
endfunction

////////////////////////////////////////
// Quadrature phase, forward order 00 01 11 10

function automatic int gray_pos(input logic [1:0] p);
	case (p)
		2'b00:   return 0;
		2'b01:   return 1;
		2'b11:   return 2;
		default: return 3;
	endcase
endfunction

function automatic logic [1:0] next_phase(input logic [1:0] p, input logic fwd);
	logic [1:0] order [4];
	int         pos;
	order = '{2'b00, 2'b01, 2'b11, 2'b10};
	pos   = (gray_pos(p) + (fwd ? 1 : 3)) % 4; // Backward is three steps forward
	return order[pos];
endfunction

////////////////////////////////////////
// Expected transition counts

// Position after a pad load, right is positive
function automatic int pad_load_value(input logic right, input logic fast);
	int mag;
	mag = fast ? 9 : 4;
	return right ? mag : -mag;
endfunction

// Negative travel drains with forward steps
function automatic int fwd_count(input int owed);
	return (owed < 0) ? -owed : 0;
endfunction

function automatic int rev_count(input int owed);
	return (owed > 0) ? owed : 0;
endfunction

// A unlike B after an A edge is forward
function automatic logic encoder_fwd(input logic a, input logic b);
	return a != b;
endfunction

`endif

/* verification/tb_arcade_inputs.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_arcade_inputs;

	localparam int STEP_CLKS      = 3000;            // One drain step, 1500 enables
	localparam int PAD_CLKS       = 96000;           // Pad repeat, 48000 enables
	localparam int QUIET_CLKS     = STEP_CLKS + 200; // Room for one stray step
	localparam int TIMEOUT_CYCLES = 500000;          // Three pad holds plus a 20 count drain

	logic        CLK_12M;
	logic        rst_n;
	logic [10:0] ps2_key;
	logic [24:0] ps2_mouse;
	logic [8:0]  joy;
	logic [3:0]  user_in;       // [3] fire, [1] B, [0] A
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [1:0]  spinner;
	logic        use_io;
	logic        btn_shot_n;
	logic        btn_1p_start_n;
	logic        btn_2p_start_n;
	logic        coin1;
	logic        coin2;
	logic        btn_service_n;
	logic [7:0]  dip_sw;

	integer      seed;
	int          errors      = 0;
	int          gray_errors = 0; // Owned by the spinner watcher
	int          tests_done  = 0;
	int          err_base    = 0;
	int          fwd_seen    = 0; // Forward steps seen on the spinner
	int          rev_seen    = 0;
	int          fwd_base    = 0;
	int          rev_base    = 0;
	int          cycle_count = 0;
	logic [8:0]  held;           // Keys held down, slot order
	logic [1:0]  last_spinner;
	logic        last_use_io;

	`include "tb_reference.svh"

	arcade_inputs_top arcade_inputs_top_i (
		.CLK_12M        (CLK_12M),
		.rst_n          (rst_n),
		.ps2_key        (ps2_key),
		.ps2_mouse      (ps2_mouse),
		.joy            (joy),
		.user_in        (user_in),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.spinner        (spinner),
		.use_io         (use_io),
		.btn_shot_n     (btn_shot_n),
		.btn_1p_start_n (btn_1p_start_n),
		.btn_2p_start_n (btn_2p_start_n),
		.coin1          (coin1),
		.coin2          (coin2),
		.btn_service_n  (btn_service_n),
		.dip_sw         (dip_sw)
	);

	initial begin
		CLK_12M = 1'b0;
		forever #10 CLK_12M = ~CLK_12M; // 50 MHz sim clock, only cycles count
	end

	////////////////////////////////////////
	// Spinner watcher, each change must be one Gray step

	always @(negedge CLK_12M) begin
		if (!rst_n) begin
			last_spinner = 2'b11;
			last_use_io  = 1'b0;
		end else begin
			// Source switch resyncs without counting
			if ((use_io == last_use_io) && (spinner != last_spinner)) begin
				if (spinner == next_phase(last_spinner, 1'b1))
					fwd_seen++;
				else if (spinner == next_phase(last_spinner, 1'b0))
					rev_seen++;
				else begin
					gray_errors++;
					$display("FAIL at %0t ns: spinner = %b, expected one step from %b",
						$time, spinner, last_spinner);
				end
			end
			last_spinner = spinner;
			last_use_io  = use_io;
		end
	end

	////////////////////////////////////////
	// Bookkeeping

	task automatic report_mismatch(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		errors++;
		$display("FAIL at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic start_test();
		err_base = errors + gray_errors;
		fwd_base = fwd_seen; // Counts are taken relative to here
		rev_base = rev_seen;
	endtask

	task automatic finish_test(input string name);
		tests_done++;
		$display("test %0d %s: %0d errors", tests_done, name, errors + gray_errors - err_base);
	endtask

	// Transition totals since start_test
	task automatic check_steps(input int exp_fwd, input int exp_rev);
		if ((fwd_seen - fwd_base) != exp_fwd)
			report_mismatch("forward steps", 32'(fwd_seen - fwd_base), 32'(exp_fwd));
		if ((rev_seen - rev_base) != exp_rev)
			report_mismatch("backward steps", 32'(rev_seen - rev_base), 32'(exp_rev));
	endtask

	////////////////////////////////////////
	// Stimulus and waits

	task automatic drive_key(input int slot, input logic pressed);
		@(posedge CLK_12M);
		ps2_key <= {~ps2_key[10], pressed, 1'b0, key_code_of(slot)}; // Toggle marks the event
		if (slot < 9)
			held[slot] = pressed;
	endtask

	task automatic send_mouse_report(input int delta);
		logic [8:0] d9;
		d9 = 9'(delta); // Sign and eight bit delta
		@(posedge CLK_12M);
		ps2_mouse[24]   <= ~ps2_mouse[24];
		ps2_mouse[15:8] <= d9[7:0];
		ps2_mouse[4]    <= d9[8];
	endtask

	task automatic write_dip(input logic [7:0] index, input logic [24:0] addr,
			input logic [7:0] data);
		@(posedge CLK_12M);
		ioctl_wr    <= 1'b1;
		ioctl_index <= index;
		ioctl_addr  <= addr;
		ioctl_dout  <= data;
		@(posedge CLK_12M);
		ioctl_wr    <= 1'b0;
	endtask

	task automatic check_buttons(input logic [5:0] exp);
		if (btn_shot_n !== exp[5])
			report_mismatch("btn_shot_n", 32'(btn_shot_n), 32'(exp[5]));
		if (btn_1p_start_n !== exp[4])
			report_mismatch("btn_1p_start_n", 32'(btn_1p_start_n), 32'(exp[4]));
		if (btn_2p_start_n !== exp[3])
			report_mismatch("btn_2p_start_n", 32'(btn_2p_start_n), 32'(exp[3]));
		if (coin1 !== exp[2])
			report_mismatch("coin1", 32'(coin1), 32'(exp[2]));
		if (coin2 !== exp[1])
			report_mismatch("coin2", 32'(coin2), 32'(exp[1]));
		if (btn_service_n !== exp[0])
			report_mismatch("btn_service_n", 32'(btn_service_n), 32'(exp[0]));
	endtask

	task automatic wait_transitions(input int target, input int limit);
		int n;
		n = 0;
		while (((fwd_seen - fwd_base) + (rev_seen - rev_base)) < target && n < limit) begin
			@(posedge CLK_12M);
			n++;
		end
		if (((fwd_seen - fwd_base) + (rev_seen - rev_base)) < target) begin
			errors++;
			$display("Spinner made only %0d of %0d steps within %0d cycles",
				(fwd_seen - fwd_base) + (rev_seen - rev_base), target, limit);
		end
	endtask

	task automatic wait_use_io(input logic level, input int limit);
		int n;
		n = 0;
		while (use_io !== level && n < limit) begin
			@(negedge CLK_12M);
			n++;
		end
		if (use_io !== level) begin
			errors++;
			$display("use_io did not go to %0d within %0d cycles", level, limit);
		end
	endtask

	// Hold the pad until the first step, then let the load drain
	task automatic run_pad_hold(input logic right, input logic fast, input string name);
		int owed;
		int total;
		owed  = pad_load_value(right, fast);
		total = fwd_count(owed) + rev_count(owed);
		start_test();
		@(posedge CLK_12M);
		joy <= {3'b000, fast, 3'b000, !right, right};
		wait_transitions(1, PAD_CLKS + 2 * STEP_CLKS);
		@(posedge CLK_12M);
		joy <= '0;
		wait_transitions(total, total * STEP_CLKS + STEP_CLKS);
		repeat (QUIET_CLKS) @(posedge CLK_12M);
		check_steps(fwd_count(owed), rev_count(owed));
		finish_test(name);
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		int         d;
		int         slot;
		int         exp_fwd;
		int         exp_rev;
		logic [1:0] pins;
		logic [2:0] addr_v;
		logic [7:0] data_v;
		logic [7:0] dip0;
		logic [7:0] exp_dip;

		seed        = 32'hac02;
		rst_n       = 1'b0;
		ps2_key     = '0;
		ps2_mouse   = '0;
		joy         = '0;
		user_in     = 4'b1111; // Encoder and fire pin idle high
		ioctl_wr    = 1'b0;
		ioctl_index = '0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		held        = '0;
		repeat (2) @(posedge CLK_12M);
		rst_n <= 1'b1;

		// Reset state
		start_test();
		@(negedge CLK_12M);
		check_buttons(merge_buttons('0, '0, '0, 1'b1));
		if (spinner !== 2'b11)
			report_mismatch("spinner", 32'(spinner), 32'h3);
		if (use_io !== 1'b0)
			report_mismatch("use_io", 32'(use_io), 32'h0);
		if (dip_sw !== 8'hFF)
			report_mismatch("dip_sw", 32'(dip_sw), 32'hFF);
		finish_test("reset");

		// Keys with random joystick, mouse buttons and fire pin
		start_test();
		for (int i = 0; i < 40; i++) begin
			slot = int'($unsigned($random(seed)) % 32'd10); // Slot 9 is an unmapped key
			drive_key(slot, 1'($random(seed)));
			joy            <= 9'($random(seed));
			ps2_mouse[1:0] <= 2'($random(seed));
			user_in[3]     <= 1'($random(seed));
			@(posedge CLK_12M);
			@(negedge CLK_12M);
			check_buttons(merge_buttons(held, joy, ps2_mouse[1:0], user_in[3]));
		end
		for (int s = 0; s < 9; s++)
			drive_key(s, 1'b0); // Break every key
		joy            <= '0;
		ps2_mouse[1:0] <= '0;
		user_in[3]     <= 1'b1;
		@(posedge CLK_12M);
		@(negedge CLK_12M);
		check_buttons(merge_buttons(held, '0, '0, 1'b1));
		finish_test("controls");

		// One mouse report, then a full drain
		start_test();
		d = int'($unsigned($random(seed)) % 32'd20) + 1;
		if (1'($random(seed)))
			d = -d;
		send_mouse_report(d);
		wait_transitions(fwd_count(d) + rev_count(d), (fwd_count(d) + rev_count(d) + 1) * STEP_CLKS);
		repeat (QUIET_CLKS) @(posedge CLK_12M);
		check_steps(fwd_count(d), rev_count(d));
		finish_test($sformatf("mouse delta %0d", d));

		run_pad_hold(1'b1, 1'b0, "pad right");
		run_pad_hold(1'b1, 1'b1, "pad right fast");
		run_pad_hold(1'b0, 1'b0, "pad left");

		// Physical encoder, B alone first so only the handover shows
		start_test();
		exp_fwd = 0;
		exp_rev = 0;
		pins    = 2'b11;
		@(posedge CLK_12M);
		pins[1]      = 1'b0;
		user_in[1:0] <= pins;
		wait_use_io(1'b1, 16);
		repeat (8) @(posedge CLK_12M);
		for (int i = 0; i < 20; i++) begin
			@(posedge CLK_12M);
			if (1'($random(seed))) begin
				pins[0] = ~pins[0];
				if (encoder_fwd(pins[0], pins[1]))
					exp_fwd++;
				else
					exp_rev++;
			end else begin
				pins[1] = ~pins[1]; // B alone, no step
			end
			user_in[1:0] <= pins;
			repeat (8) @(posedge CLK_12M);
		end
		check_steps(exp_fwd, exp_rev);
		if (use_io !== 1'b1)
			report_mismatch("use_io", 32'(use_io), 32'h1);
		send_mouse_report(0); // Zero delta, activity only
		wait_use_io(1'b0, 16);
		finish_test("physical encoder");

		// DIP download
		start_test();
		dip0 = '0;
		for (int a = 0; a < 12; a++) begin
			addr_v = (a < 8) ? 3'(a) : 3'($random(seed)); // Every address, then a few again
			data_v = 8'($random(seed));
			write_dip(8'd254, 25'(addr_v), data_v);
			if (addr_v == 3'd0)
				dip0 = data_v;
		end
		write_dip(8'd253, 25'd0, ~dip0); // Other slot
		write_dip(8'd254, 25'd8, ~dip0); // Past the bank
		@(posedge CLK_12M);
		@(negedge CLK_12M);
		exp_dip = ~dip0;
		if (dip_sw !== exp_dip)
			report_mismatch("dip_sw", 32'(dip_sw), 32'(exp_dip));
		finish_test("dip switches");

		$display("tests %0d, errors %0d", tests_done, errors + gray_errors);
		if (errors + gray_errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Timeout

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge CLK_12M);
			cycle_count++;
		end
		$display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
